// File: design/cpu_pkg.sv
package cpu_pkg;

	localparam int word_width = 32;
	localparam int inst_addr_width = 16;
	localparam int data_addr_width = 16;
	localparam int reg_count = 32;
	localparam int reg_addr_width = 5;

	// timer prescaler, clocks per millisecond tick
	localparam int cycles_per_ms = 8;
	localparam int prescale_width = $clog2(cycles_per_ms);

	typedef enum logic [4:0] {
		op_add  = 5'b00000,
		op_addi = 5'b00001,
		op_sub  = 5'b00010,
		op_and  = 5'b00011,
		op_andi = 5'b00100,
		op_or   = 5'b00101,
		op_ori  = 5'b00110,
		op_xor  = 5'b00111,
		op_sll  = 5'b01000,
		op_srl  = 5'b01001,
		op_sra  = 5'b01010,
		op_lli  = 5'b01011,
		op_lui  = 5'b01100,
		op_lw   = 5'b01101,
		op_sw   = 5'b01110,
		op_lwo  = 5'b01111,
		op_swo  = 5'b10000,
		op_b    = 5'b10001,
		op_bl   = 5'b10010,
		op_ret  = 5'b10011,
		op_tim  = 5'b11101
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_e;

	typedef enum logic [2:0] {
		cond_bne,
		cond_beq,
		cond_bgt,
		cond_blt,
		cond_bge,
		cond_ble,
		cond_bover,
		cond_always
	} branch_cond_e;

	typedef enum logic [2:0] {
		st_fetch_req,
		st_fetch_release,
		st_execute,
		st_mem_req,
		st_mem_release,
		st_writeback
	} cpu_state_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_immediate;
		logic select_immediate;
		logic select_time;
		logic update_flags;
		logic write_reg;
		logic write_lower;
		logic write_upper;
		logic mem_read;
		logic mem_write;
		logic branch;
		logic link;
		logic link_return;
		logic use_dest_as_op2;
	} ctrl_t;

	////////////////////////////////////////////////////////////////////
	// memory ports, four-phase req/ack
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic req;
		logic [inst_addr_width-1:0] addr;
	} imem_req_t;

	typedef struct packed {
		logic ack;
		logic [word_width-1:0] data;
	} imem_rsp_t;

	typedef struct packed {
		logic req;
		logic write;
		logic [data_addr_width-1:0] addr;
		logic [word_width-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic ack;
		logic [word_width-1:0] rdata;
	} dmem_rsp_t;

endpackage

// File: design/fetch_unit.sv
module fetch_unit import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic load_instruction,
	input  logic [word_width-1:0] fetched,
	input  logic commit,
	input  ctrl_t ctrl,
	input  logic take_branch,
	input  logic [inst_addr_width-1:0] branch_target,
	output logic [word_width-1:0] instruction,
	output logic [inst_addr_width-1:0] pc
);

	logic [inst_addr_width-1:0] link_reg;
	logic [inst_addr_width-1:0] pc_plus_one;

	// instruction memory is word addressed
	assign pc_plus_one = pc + 1'b1;

	always_ff @(posedge clk) begin
		if (load_instruction) begin
			instruction <= fetched;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			link_reg <= '0;
		end else if (commit) begin
			if (take_branch) begin
				pc <= branch_target;
			end else if (ctrl.link_return) begin
				pc <= link_reg;
			end else begin
				pc <= pc_plus_one;
			end
			// only a taken bl saves the return point
			if (take_branch && ctrl.link) begin
				link_reg <= pc_plus_one;
			end
		end
	end

endmodule

// File: design/control_fsm.sv
module control_fsm import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  ctrl_t ctrl,
	input  logic [inst_addr_width-1:0] pc,
	input  logic [word_width-1:0] mem_addr,
	input  logic [word_width-1:0] store_data,
	output imem_req_t imem_req,
	input  imem_rsp_t imem_rsp,
	output dmem_req_t dmem_req,
	input  dmem_rsp_t dmem_rsp,
	output logic [word_width-1:0] fetched,
	output logic load_instruction,
	output logic [word_width-1:0] load_data,
	output logic commit
);

	cpu_state_e state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_fetch_req;
			imem_req <= '0;
			dmem_req <= '0;
			load_instruction <= 1'b0;
		end else begin
			load_instruction <= 1'b0;
			case (state)
				st_fetch_req: begin
					// raise req once, then hold it until ack
					if (!imem_req.req) begin
						imem_req.req <= 1'b1;
						imem_req.addr <= pc;
					end else if (imem_rsp.ack) begin
						imem_req.req <= 1'b0;
						load_instruction <= 1'b1;
						state <= st_fetch_release;
					end
				end
				st_fetch_release: begin
					if (!imem_rsp.ack) begin
						state <= st_execute;
					end
				end
				st_execute: begin
					if (ctrl.mem_read || ctrl.mem_write) begin
						dmem_req.req <= 1'b1;
						dmem_req.write <= ctrl.mem_write;
						dmem_req.addr <= mem_addr[data_addr_width-1:0];
						dmem_req.wdata <= store_data;
						state <= st_mem_req;
					end else begin
						state <= st_writeback;
					end
				end
				st_mem_req: begin
					if (dmem_rsp.ack) begin
						dmem_req.req <= 1'b0;
						state <= st_mem_release;
					end
				end
				st_mem_release: begin
					if (!dmem_rsp.ack) begin
						state <= st_writeback;
					end
				end
				st_writeback: state <= st_fetch_req;
				default: state <= st_fetch_req;
			endcase
		end
	end

	// capture read data while req and ack are both high
	always_ff @(posedge clk) begin
		if (state == st_fetch_req && imem_req.req && imem_rsp.ack) begin
			fetched <= imem_rsp.data;
		end
		if (state == st_mem_req && dmem_rsp.ack) begin
			load_data <= dmem_rsp.rdata;
		end
	end

	assign commit = (state == st_writeback);

endmodule

// File: design/instruction_decoder.sv
module instruction_decoder import cpu_pkg::*; (
	input  logic [word_width-1:0] instruction,
	output ctrl_t ctrl
);

	opcode_e op;

	assign op = opcode_e'(instruction[31:27]);

	always_comb begin
		// dropped peripheral opcodes fall through as no-ops
		ctrl = '0;
		case (op)
			op_add, op_addi: begin
				ctrl.alu_op = alu_add;
				ctrl.use_immediate = (op == op_addi);
				ctrl.update_flags = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_sub: begin
				ctrl.alu_op = alu_sub;
				ctrl.update_flags = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_and, op_andi: begin
				ctrl.alu_op = alu_and;
				ctrl.use_immediate = (op == op_andi);
				ctrl.update_flags = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_or, op_ori: begin
				ctrl.alu_op = alu_or;
				ctrl.use_immediate = (op == op_ori);
				ctrl.update_flags = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_xor, op_sll, op_srl, op_sra: begin
				ctrl.alu_op = (op == op_xor) ? alu_xor :
					(op == op_sll) ? alu_sll :
					(op == op_srl) ? alu_srl : alu_sra;
				ctrl.update_flags = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_lli, op_lui: begin
				ctrl.select_immediate = 1'b1;
				ctrl.write_lower = (op == op_lli);
				ctrl.write_upper = (op == op_lui);
			end
			op_lw, op_lwo: begin
				ctrl.use_immediate = (op == op_lwo);
				ctrl.mem_read = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			op_sw, op_swo: begin
				// store data comes from the destination field
				ctrl.use_immediate = (op == op_swo);
				ctrl.mem_write = 1'b1;
				ctrl.use_dest_as_op2 = 1'b1;
			end
			op_b: ctrl.branch = 1'b1;
			op_bl: begin
				ctrl.branch = 1'b1;
				ctrl.link = 1'b1;
			end
			op_ret: ctrl.link_return = 1'b1;
			op_tim: begin
				ctrl.select_time = 1'b1;
				ctrl.write_reg = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// File: design/register_file.sv
module register_file import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic [word_width-1:0] instruction,
	input  ctrl_t ctrl,
	input  logic commit,
	input  logic [word_width-1:0] write_data,
	output logic [word_width-1:0] op1,
	output logic [word_width-1:0] op2
);

	logic [word_width-1:0] regs [reg_count];
	logic [reg_addr_width-1:0] dest;
	logic [reg_addr_width-1:0] src1;
	logic [reg_addr_width-1:0] src2;

	assign dest = instruction[26:22];
	assign src1 = instruction[21:17];
	assign src2 = ctrl.use_dest_as_op2 ? dest : instruction[16:12];

	assign op1 = regs[src1];
	assign op2 = regs[src2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && dest != '0) begin
			// half-word writes take the low half of the immediate
			if (ctrl.write_lower) begin
				regs[dest][15:0] <= write_data[15:0];
			end else if (ctrl.write_upper) begin
				regs[dest][31:16] <= write_data[15:0];
			end else if (ctrl.write_reg) begin
				regs[dest] <= write_data;
			end
		end
	end

endmodule

// File: design/execute_unit.sv
module execute_unit import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic [word_width-1:0] instruction,
	input  ctrl_t ctrl,
	input  logic [word_width-1:0] op1,
	input  logic [word_width-1:0] op2,
	input  logic [inst_addr_width-1:0] pc,
	input  logic [word_width-1:0] time_ms,
	input  logic commit,
	output logic [word_width-1:0] result,
	output logic take_branch,
	output logic [inst_addr_width-1:0] branch_target
);

	logic [word_width-1:0] imm;
	logic [word_width-1:0] alu_b;
	logic [word_width-1:0] alu_result;
	logic alu_overflow;
	logic flag_zero;
	logic flag_sign;
	logic flag_overflow;
	logic cond_met;
	branch_cond_e cond;

	assign imm = {{(word_width-16){instruction[15]}}, instruction[15:0]};
	assign cond = branch_cond_e'(instruction[26:24]);

	// plain lw/sw address with the first source alone
	assign alu_b = ctrl.use_immediate ? imm :
		(ctrl.mem_read || ctrl.mem_write) ? '0 : op2;

	always_comb begin
		alu_result = op1 + alu_b;
		alu_overflow = 1'b0;
		case (ctrl.alu_op)
			alu_add: begin
				alu_overflow = (op1[word_width-1] == alu_b[word_width-1]) &&
					(alu_result[word_width-1] != op1[word_width-1]);
			end
			alu_sub: begin
				alu_result = op1 - alu_b;
				alu_overflow = (op1[word_width-1] != alu_b[word_width-1]) &&
					(alu_result[word_width-1] != op1[word_width-1]);
			end
			alu_and: alu_result = op1 & alu_b;
			alu_or: alu_result = op1 | alu_b;
			alu_xor: alu_result = op1 ^ alu_b;
			alu_sll: alu_result = op1 << alu_b[4:0];
			alu_srl: alu_result = op1 >> alu_b[4:0];
			alu_sra: alu_result = $signed(op1) >>> alu_b[4:0];
			default: alu_result = op1 + alu_b;
		endcase
	end

	assign result = ctrl.select_immediate ? imm :
		ctrl.select_time ? time_ms : alu_result;

	// zero, sign, overflow status
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_zero <= 1'b0;
			flag_sign <= 1'b0;
			flag_overflow <= 1'b0;
		end else if (commit && ctrl.update_flags) begin
			flag_zero <= (alu_result == '0);
			flag_sign <= alu_result[word_width-1];
			flag_overflow <= alu_overflow;
		end
	end

	always_comb begin
		case (cond)
			cond_bne: cond_met = !flag_zero;
			cond_beq: cond_met = flag_zero;
			cond_bgt: cond_met = !flag_zero && !flag_sign;
			cond_blt: cond_met = !flag_zero && flag_sign;
			cond_bge: cond_met = flag_zero || !flag_sign;
			cond_ble: cond_met = flag_zero || flag_sign;
			cond_bover: cond_met = flag_overflow;
			default: cond_met = 1'b1;
		endcase
	end

	assign take_branch = ctrl.branch && cond_met;
	assign branch_target = pc + 1'b1 + imm[inst_addr_width-1:0];

endmodule

// File: design/ms_timer.sv
module ms_timer import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output logic [word_width-1:0] time_ms
);

	logic [prescale_width-1:0] prescale;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescale <= '0;
			time_ms <= '0;
		end else if (prescale == prescale_width'(cycles_per_ms - 1)) begin
			prescale <= '0;
			time_ms <= time_ms + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: design/cpu_core.sv
module cpu_core import cpu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output imem_req_t imem_req,
	input  imem_rsp_t imem_rsp,
	output dmem_req_t dmem_req,
	input  dmem_rsp_t dmem_rsp
);

	logic [word_width-1:0] instruction;
	logic [inst_addr_width-1:0] pc;
	ctrl_t ctrl;
	logic [word_width-1:0] op1;
	logic [word_width-1:0] op2;
	logic [word_width-1:0] result;
	logic take_branch;
	logic [inst_addr_width-1:0] branch_target;
	logic [word_width-1:0] time_ms;
	logic [word_width-1:0] fetched;
	logic load_instruction;
	logic [word_width-1:0] load_data;
	logic commit;
	logic [word_width-1:0] write_data;

	// loads write back memory data, everything else the execute result
	assign write_data = ctrl.mem_read ? load_data : result;

	////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////

	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.load_instruction(load_instruction),
		.fetched(fetched),
		.commit(commit),
		.ctrl(ctrl),
		.take_branch(take_branch),
		.branch_target(branch_target),
		.instruction(instruction),
		.pc(pc)
	);

	instruction_decoder u_decoder (
		.instruction(instruction),
		.ctrl(ctrl)
	);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.instruction(instruction),
		.ctrl(ctrl),
		.commit(commit),
		.write_data(write_data),
		.op1(op1),
		.op2(op2)
	);

	execute_unit u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.instruction(instruction),
		.ctrl(ctrl),
		.op1(op1),
		.op2(op2),
		.pc(pc),
		.time_ms(time_ms),
		.commit(commit),
		.result(result),
		.take_branch(take_branch),
		.branch_target(branch_target)
	);

	ms_timer u_timer (
		.clk(clk),
		.rst_n(rst_n),
		.time_ms(time_ms)
	);

	////////////////////////////////////////////////////////////////////
	// sequencer and memory ports
	////////////////////////////////////////////////////////////////////

	control_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.pc(pc),
		.mem_addr(result),
		.store_data(op2),
		.imem_req(imem_req),
		.imem_rsp(imem_rsp),
		.dmem_req(dmem_req),
		.dmem_rsp(dmem_rsp),
		.fetched(fetched),
		.load_instruction(load_instruction),
		.load_data(load_data),
		.commit(commit)
	);

endmodule

// File: dv/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

	logic clk;
	logic rst_n;
	imem_req_t imem_req;
	imem_rsp_t imem_rsp;
	dmem_req_t dmem_req;
	dmem_rsp_t dmem_rsp;

	logic [31:0] imem [0:65535];
	logic [31:0] dmem [0:65535];
	logic [15:0] exp_addr [$];
	logic [31:0] exp_data [$];
	bit exp_time [$];

	int store_index = 0;
	int error_count = 0;
	int cycles = 0;
	logic [31:0] last_time = '0;
	logic [31:0] lfsr_state;

	cpu_core DUT (
		.clk(clk),
		.rst_n(rst_n),
		.imem_req(imem_req),
		.imem_rsp(imem_rsp),
		.dmem_req(dmem_req),
		.dmem_rsp(dmem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// cycles since reset release bound the timer
	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		error_count++;
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// two bits with one lfsr step each
	task automatic random_delay(output int d);
		d = 0;
		for (int i = 0; i < 2; i++) begin
			d = d | (int'(lfsr_state[0]) << i);
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string line;
		logic [15:0] kind;
		logic [31:0] a;
		logic [31:0] v;
		for (int i = 0; i < 65536; i++) begin
			// unused opcode 31 decodes as a no-op
			imem[i] = 32'hF8000000 | i;
			dmem[i] = {~16'(i), 16'(i)};
		end
		fd = $fopen("dv/cpu_trace.txt", "r");
		if (fd == 0) begin
			stop_on_error("cannot open the trace file dv/cpu_trace.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %h %h", kind, a, v);
				if (n != 3) begin
					stop_on_error({"malformed trace line: ", line});
				end
				case (kind)
					"I": imem[a[15:0]] = v;
					"D": dmem[a[15:0]] = v;
					"S", "ST": begin
						exp_addr.push_back(a[15:0]);
						exp_data.push_back(v);
						exp_time.push_back(kind == "ST");
					end
					default: stop_on_error({"unknown trace line kind: ", line});
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic check_store(input logic [15:0] addr, input logic [31:0] data);
		assert (store_index < exp_addr.size()) else
			stop_on_error($sformatf("store beyond the end of the trace, address %h", addr));
		assert (addr == exp_addr[store_index]) else
			stop_on_error($sformatf("FAIL %0t: store %0d to address %h, expected %h",
				$time, store_index, addr, exp_addr[store_index]));
		if (exp_time[store_index]) begin
			assert (data >= last_time) else
				stop_on_error($sformatf("FAIL %0t: timer %0d below previous %0d",
					$time, data, last_time));
			assert (data <= 32'(cycles / cycles_per_ms)) else
				stop_on_error($sformatf("FAIL %0t: timer %0d ahead of %0d cycles",
					$time, data, cycles));
			last_time = data;
		end else begin
			assert (data == exp_data[store_index]) else
				stop_on_error($sformatf("FAIL %0t: store %0d data %h, expected %h",
					$time, store_index, data, exp_data[store_index]));
		end
		store_index++;
	endtask

	////////////////////////////////////////////////////////////////////
	// memory responders
	////////////////////////////////////////////////////////////////////

	initial begin : imem_responder
		int timeout;
		int d;
		bit first;
		first = 1'b1;
		wait_cycle();
		forever begin
			timeout = 0;
			while (!imem_req.req) begin
				wait_cycle();
				timeout++;
				if (timeout > 200) stop_on_error("timeout waiting for a fetch request");
			end
			if (first) begin
				assert (imem_req.addr == '0) else
					stop_on_error($sformatf("FAIL %0t: first fetch from %h", $time, imem_req.addr));
				first = 1'b0;
			end
			random_delay(d);
			repeat (d) wait_cycle();
			imem_rsp.data = imem[imem_req.addr];
			imem_rsp.ack = 1'b1;
			timeout = 0;
			while (imem_req.req) begin
				wait_cycle();
				timeout++;
				if (timeout > 200) stop_on_error("timeout waiting for fetch req to drop");
			end
			imem_rsp.ack = 1'b0;
		end
	end

	initial begin : dmem_responder
		int timeout;
		int d;
		wait_cycle();
		forever begin
			timeout = 0;
			while (!dmem_req.req) begin
				wait_cycle();
				timeout++;
				if (timeout > 5000) stop_on_error("timeout waiting for a data request");
			end
			random_delay(d);
			repeat (d) wait_cycle();
			if (dmem_req.write) begin
				check_store(dmem_req.addr, dmem_req.wdata);
				dmem[dmem_req.addr] = dmem_req.wdata;
			end else begin
				dmem_rsp.rdata = dmem[dmem_req.addr];
			end
			dmem_rsp.ack = 1'b1;
			timeout = 0;
			while (dmem_req.req) begin
				wait_cycle();
				timeout++;
				if (timeout > 200) stop_on_error("timeout waiting for data req to drop");
			end
			dmem_rsp.ack = 1'b0;
		end
	end

	// four-phase rules sampled mid-cycle
	imem_req_t prev_ireq;
	dmem_req_t prev_dreq;
	logic prev_iack;
	logic prev_dack;
	logic have_prev = 1'b0;

	always @(negedge clk) begin
		if (!rst_n) begin
			assert (!imem_req.req && !dmem_req.req) else
				stop_on_error($sformatf("FAIL %0t: a request was raised during reset", $time));
		end else if (have_prev) begin
			if (prev_ireq.req && !prev_iack) begin
				assert (imem_req.req) else
					stop_on_error($sformatf("FAIL %0t: fetch req dropped before ack", $time));
			end
			if (prev_ireq.req && imem_req.req) begin
				assert (imem_req.addr == prev_ireq.addr) else
					stop_on_error($sformatf("FAIL %0t: fetch addr changed under req", $time));
			end
			if (!prev_ireq.req && imem_req.req) begin
				assert (!prev_iack) else
					stop_on_error($sformatf("FAIL %0t: fetch req raised with ack high", $time));
			end
			if (prev_dreq.req && !prev_dack) begin
				assert (dmem_req.req) else
					stop_on_error($sformatf("FAIL %0t: data req dropped before ack", $time));
			end
			if (prev_dreq.req && dmem_req.req) begin
				assert (dmem_req == prev_dreq) else
					stop_on_error($sformatf("FAIL %0t: data request changed under req", $time));
			end
			if (!prev_dreq.req && dmem_req.req) begin
				assert (!prev_dack) else
					stop_on_error($sformatf("FAIL %0t: data req raised with ack high", $time));
			end
		end
		prev_ireq = imem_req;
		prev_dreq = dmem_req;
		prev_iack = imem_rsp.ack;
		prev_dack = dmem_rsp.ack;
		have_prev = rst_n;
	end

	initial begin : main
		int timeout;
		rst_n = 1'b0;
		imem_rsp = '0;
		dmem_rsp = '0;
		lfsr_state = 32'h8790;
		load_trace();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		timeout = 0;
		while (store_index < exp_addr.size()) begin
			wait_cycle();
			timeout++;
			if (timeout > 20000) stop_on_error("timeout waiting for the expected stores");
		end
		if (error_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// File: dv/cpu_trace.txt
# kind addr value (hex): I program word, D data preload, S expected store
# ST expects a timer value at addr, its value column is ignored
I 0000 08400064
I 0001 0880FFF9
I 0002 00C22000
I 0003 80C00100
I 0004 11041000
I 0005 81000101
I 0006 19422000
I 0007 81400102
I 0008 29422000
I 0009 81400103
I 000A 39422000
I 000B 81400104
I 000C 41441000
I 000D 81400105
I 000E 49441000
I 000F 81400106
I 0010 51441000
I 0011 81400107
I 0012 2142FF0F
I 0013 81400108
I 0014 31421200
I 0015 81400109
I 0016 59805678
I 0017 61801234
I 0018 71820000
I 0019 08000037
I 001A 8000010A
I 001B 09C00200
I 001C 6A0E0000
I 001D 8200010B
I 001E 7A400100
I 001F 8240010C
I 0020 88000001
I 0021 800001FF
I 0022 8A000001
I 0023 800001FF
I 0024 8C000001
I 0025 800001FF
I 0026 8900001D
I 0027 8B00001C
I 0028 8D00001B
I 0029 11421000
I 002A 89000001
I 002B 800001FF
I 002C 8D000001
I 002D 800001FF
I 002E 88000015
I 002F 8A000014
I 0030 01440000
I 0031 8B000001
I 0032 800001FF
I 0033 8C000010
I 0034 8E00000F
I 0035 61407FFF
I 0036 5940FFFF
I 0037 094A0001
I 0038 8E000001
I 0039 800001FF
I 003A 8140010D
I 003B 97000006
I 003C 80C0010F
I 003D E8400000
I 003E 80400110
I 003F E8400000
I 0040 80400111
I 0041 8F00FFFF
I 0042 8100010E
I 0043 98000000
I 0044 800001FF
D 0200 CAFEF00D
S 0100 0000005D
S 0101 FFFFFF95
S 0102 00000060
S 0103 FFFFFFFD
S 0104 FFFFFF9D
S 0105 FFFFFF90
S 0106 0FFFFFFF
S 0107 FFFFFFFF
S 0108 00000004
S 0109 00001264
S 0064 12345678
S 010A 00000000
S 010B CAFEF00D
S 010C 0000005D
S 010D 80000000
S 010E FFFFFF95
S 010F 0000005D
ST 0110 00000000
ST 0111 00000000

// File: project.f
design/cpu_pkg.sv
design/fetch_unit.sv
design/control_fsm.sv
design/instruction_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/ms_timer.sv
design/cpu_core.sv
dv/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f project.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpu_sim 2>&1)
status=$?
echo "$output"

if [ $status -eq 0 ] && echo "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
